// ==== design/vid_sync_macros.svh ====
/*
 * Video sync conditioning constants
 * Counter width and input sampling depth for the sync path
 */

`ifndef VID_SYNC_MACROS_SVH
`define VID_SYNC_MACROS_SVH

// Width of run-length and line position counters
`define SYNC_CNT_W 16

// Largest count before a counter holds its value
`define SYNC_CNT_MAX {`SYNC_CNT_W{1'b1}}

// Input sampling registers ahead of the edge compare
// The compare looks at the last two stages so two is the minimum
`define SYNC_STAGES 2

`endif

// ==== design/vid_sync_pkg.sv ====
/*
 * Shared types for the sync conditioning path
 * Cycle counts, the hs/vs pair and the composite generator mode
 */

`include "vid_sync_macros.svh"

package vid_sync_pkg;

	// Count of clk_sys cycles
	typedef logic [`SYNC_CNT_W-1:0] sync_cnt_t;

	// Sync pair with active-high members after normalisation
	typedef struct packed {
		logic hs;
		logic vs;
	} vid_sync_t;

	// Composite sync generator mode
	typedef enum logic {
		CS_LINE  = 1'b0,
		CS_VSYNC = 1'b1
	} cs_mode_t;

	// Saturating increment shared by all counters
	// Long idle periods must not wrap back to a short count
	function automatic sync_cnt_t cnt_inc(input sync_cnt_t cnt);
		sync_cnt_t res;
		if (cnt == `SYNC_CNT_MAX) begin
			res = cnt;
		end else begin
			res = cnt + 1'b1;
		end
		return res;
	endfunction

endpackage

// ==== design/sync_polarity.sv ====
/*
 * Sync polarity normaliser
 * Compares the last high and low run lengths of one sync input
 * and drives the input out with its active (shorter) level high
 */

`include "vid_sync_macros.svh"

module sync_polarity
	import vid_sync_pkg::*;
(
	input  logic clk_sys,
	input  logic resetd,
	input  logic i_sync,
	output logic o_sync
);

	// Sampling chain, newest sample in bit 0
	logic [`SYNC_STAGES-1:0] samp;

	// Last two sampled levels
	logic lvl_new;
	logic lvl_old;
	logic run_done;

	// Run length bookkeeping
	sync_cnt_t run_cnt;
	sync_cnt_t hi_run;
	sync_cnt_t lo_run;

	// Set when the high level is the inactive one
	logic pol;

	////////////////////
	// Input sampling
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			samp <= '0;
		end else begin
			samp <= {samp[`SYNC_STAGES-2:0], i_sync};
		end
	end

	assign lvl_new = samp[`SYNC_STAGES-2];
	assign lvl_old = samp[`SYNC_STAGES-1];

	// A run ends when the level moving into the last stage differs
	assign run_done = (lvl_new != lvl_old);

	////////////////////
	// Run measurement
	////////////////////

	// Cycles since the last sampled edge
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			run_cnt <= '0;
		end else if (run_done) begin
			run_cnt <= '0;
		end else begin
			run_cnt <= cnt_inc(run_cnt);
		end
	end

	// File the finished run under the level that just ended
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hi_run <= '0;
			lo_run <= '0;
		end else if (run_done) begin
			if (lvl_old) begin
				hi_run <= run_cnt;
			end else begin
				lo_run <= run_cnt;
			end
		end
	end

	// Sync pulses are the short level
	// so a longer high run means the input is active low
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			pol <= 1'b0;
		end else begin
			pol <= (hi_run > lo_run);
		end
	end

	////////////////////
	// Output
	////////////////////

	// Third register after the input pin
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_sync <= 1'b0;
		end else begin
			o_sync <= lvl_old ^ pol;
		end
	end

endmodule

// ==== design/csync_gen.sv ====
/*
 * Composite sync generator
 * Merges a normalised hs/vs pair into one active-high csync
 * During vsync the horizontal part is serrated
 */

module csync_gen
	import vid_sync_pkg::*;
(
	input  logic      clk_sys,
	input  logic      resetd,
	input  vid_sync_t i_sync,
	output logic      o_cs
);

	// Horizontal edge detection
	logic hs_prev;
	logic hs_rise;
	logic hs_fall;

	// Line timing measured from hs
	sync_cnt_t h_cnt;
	sync_cnt_t hs_len;
	sync_cnt_t line_len;

	// Registered vs as the generator mode
	cs_mode_t mode;

	// Horizontal part of the composite
	logic cs_h;
	logic cs_h_next;

	////////////////////
	// hs edges
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_prev <= 1'b0;
		end else begin
			hs_prev <= i_sync.hs;
		end
	end

	assign hs_rise = i_sync.hs & ~hs_prev;
	assign hs_fall = ~i_sync.hs & hs_prev;

	////////////////////
	// Line timing
	////////////////////

	// Restarts on both hs edges
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			h_cnt <= '0;
		end else if (hs_rise || hs_fall) begin
			h_cnt <= '0;
		end else begin
			h_cnt <= cnt_inc(h_cnt);
		end
	end

	// At the falling edge h_cnt holds the hs pulse width
	// At the rising edge it holds the gap since that pulse
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			hs_len   <= '0;
			line_len <= '0;
		end else begin
			if (hs_fall) begin
				hs_len <= h_cnt;
			end
			if (hs_rise) begin
				line_len <= h_cnt - hs_len;
			end
		end
	end

	////////////////////
	// Mode
	////////////////////

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			mode <= CS_LINE;
		end else if (i_sync.vs) begin
			mode <= CS_VSYNC;
		end else begin
			mode <= CS_LINE;
		end
	end

	////////////////////
	// Composite output
	////////////////////

	// Outside vsync the horizontal part is plain hs
	// Inside vsync it drops at each hs start and rises once the
	// line counter reaches the measured line length
	always_comb begin
		case (mode)
			CS_VSYNC: begin
				if (hs_rise) begin
					cs_h_next = 1'b0;
				end else if (h_cnt == line_len) begin
					cs_h_next = 1'b1;
				end else begin
					cs_h_next = cs_h;
				end
			end
			default: begin
				cs_h_next = i_sync.hs;
			end
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			cs_h <= 1'b0;
		end else begin
			cs_h <= cs_h_next;
		end
	end

	// vs inverts the horizontal part for the whole vsync period
	// o_cs always equals cs_h XOR the registered vs
	always_ff @(posedge clk_sys) begin
		if (resetd) begin
			o_cs <= 1'b0;
		end else begin
			o_cs <= cs_h_next ^ i_sync.vs;
		end
	end

endmodule

// ==== design/vid_sync_top.sv ====
/*
 * Sync conditioning top level
 * Two polarity normalisers feeding the composite sync generator
 */

module vid_sync_top
	import vid_sync_pkg::*;
(
	input  logic      clk_sys,
	input  logic      resetd,
	input  vid_sync_t i_sync_raw,
	output vid_sync_t o_sync,
	output logic      o_cs
);

	// Normalised levels from each channel
	logic      hs_norm;
	logic      vs_norm;

	// Joined pair for the generator and the outputs
	vid_sync_t sync_norm;

	////////////////////
	// Polarity normalisers
	////////////////////

	sync_polarity u_hs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_sync_raw.hs),
		.o_sync  (hs_norm)
	);

	sync_polarity u_vs (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (i_sync_raw.vs),
		.o_sync  (vs_norm)
	);

	assign sync_norm.hs = hs_norm;
	assign sync_norm.vs = vs_norm;

	////////////////////
	// Composite sync
	////////////////////

	// One register stage behind o_sync
	csync_gen u_csync (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (sync_norm),
		.o_cs    (o_cs)
	);

	assign o_sync = sync_norm;

endmodule

// ==== verif/vid_sync_props.sv ====
/*
 * Bound checks for the sync conditioning top level
 * Reset values and the composite relation outside vsync
 */

module vid_sync_props
	import vid_sync_pkg::*;
(
	input logic      clk_sys,
	input logic      resetd,
	input vid_sync_t i_sync,
	input logic      i_cs
);

	timeunit 1ns;
	timeprecision 100ps;

	// Outputs come out of reset cleared
	a_reset_clear: assert property (@(posedge clk_sys)
		resetd |=> (i_sync == '0 && !i_cs))
		else $error("Sync outputs not cleared after reset");

	// Two cycles of vs low put the generator in line mode
	// and the composite then repeats the previous hs
	a_line_follow: assert property (@(posedge clk_sys) disable iff (resetd)
		(!$past(i_sync.vs) && !$past(i_sync.vs, 2)) |-> (i_cs == $past(i_sync.hs)))
		else $error("Composite sync does not follow hs outside vsync");

endmodule

// ==== verif/tb_vid_sync.sv ====
/*
 * Testbench for the sync conditioning top level
 * Random frame sets of random polarity, checked against a cycle model
 */

`include "vid_sync_macros.svh"

module tb_vid_sync
	import vid_sync_pkg::*;
();

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RST_CYCLES = 10;
	localparam int FRAME_SETS = 6;
	localparam int WAIT_LIMIT = 64;

	logic      clk_sys = 1'b0;
	logic      resetd;
	vid_sync_t i_sync_raw;
	vid_sync_t o_sync;
	logic      o_cs;

	// Model state, channel 0 is hs and 1 is vs
	logic [1:0] m_samp [2];
	sync_cnt_t  m_run [2];
	sync_cnt_t  m_hi [2];
	sync_cnt_t  m_lo [2];
	logic       m_pol [2];
	vid_sync_t  m_sync;
	logic       m_hs_prev;
	sync_cnt_t  m_h_cnt;
	sync_cnt_t  m_hs_len;
	sync_cnt_t  m_line_len;
	cs_mode_t   m_mode;
	logic       m_cs_h;
	logic       m_cs;
	logic       m_live = 1'b0;

	logic [31:0] seed = 32'hdddd;
	int          n_checked = 0;
	int          n_vsync = 0;

	vid_sync_top DUT (
		.clk_sys    (clk_sys),
		.resetd     (resetd),
		.i_sync_raw (i_sync_raw),
		.o_sync     (o_sync),
		.o_cs       (o_cs)
	);

	bind vid_sync_top vid_sync_props u_props (
		.clk_sys (clk_sys),
		.resetd  (resetd),
		.i_sync  (o_sync),
		.i_cs    (o_cs)
	);

	always #4 clk_sys = ~clk_sys;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Value in lo .. lo+span-1 from the upper LCG bits
	function automatic int pick(input int lo, input int span);
		seed = lcg_next(seed);
		return lo + int'(seed[31:16]) % span;
	endfunction

	function automatic sync_cnt_t sat_next(input sync_cnt_t c);
		return (&c) ? c : c + sync_cnt_t'(1);
	endfunction

	////////////////////
	// Reference model
	////////////////////

	// One clk_sys edge of the whole path, all updates from pre-edge state
	function automatic void model_step(input logic rst, input vid_sync_t raw);
		logic [1:0] in_lvl;
		logic [1:0] nxt;
		logic       hs;
		logic       vs;
		logic       rise;
		logic       fall;
		logic       cs_next;
		in_lvl = {raw.vs, raw.hs};
		hs = m_sync.hs;
		vs = m_sync.vs;
		rise = hs && !m_hs_prev;
		fall = !hs && m_hs_prev;
		if (m_mode == CS_VSYNC) begin
			if (rise) begin
				cs_next = 1'b0;
			end else if (m_h_cnt == m_line_len) begin
				cs_next = 1'b1;
			end else begin
				cs_next = m_cs_h;
			end
		end else begin
			cs_next = hs;
		end
		m_cs = rst ? 1'b0 : cs_next ^ vs;
		m_cs_h = rst ? 1'b0 : cs_next;
		m_mode = (vs && !rst) ? CS_VSYNC : CS_LINE;
		if (fall) begin
			m_hs_len = m_h_cnt;
		end
		if (rise) begin
			m_line_len = m_h_cnt - m_hs_len;
		end
		m_h_cnt = (rise || fall) ? '0 : sat_next(m_h_cnt);
		m_hs_prev = hs;
		// Normalisers, output first so it sees the old flag
		for (int ch = 0; ch < 2; ch++) begin
			nxt[ch] = m_samp[ch][1] ^ m_pol[ch];
			m_pol[ch] = m_hi[ch] > m_lo[ch];
			if (m_samp[ch][1] != m_samp[ch][0]) begin
				if (m_samp[ch][1]) begin
					m_hi[ch] = m_run[ch];
				end else begin
					m_lo[ch] = m_run[ch];
				end
				m_run[ch] = '0;
			end else begin
				m_run[ch] = sat_next(m_run[ch]);
			end
			m_samp[ch] = {m_samp[ch][0], in_lvl[ch]};
		end
		m_sync.hs = nxt[0];
		m_sync.vs = nxt[1];
		if (rst) begin
			for (int ch = 0; ch < 2; ch++) begin
				m_samp[ch] = '0;
				m_run[ch] = '0;
				m_hi[ch] = '0;
				m_lo[ch] = '0;
				m_pol[ch] = 1'b0;
			end
			m_sync = '0;
			m_hs_prev = 1'b0;
			m_h_cnt = '0;
			m_hs_len = '0;
			m_line_len = '0;
			m_live = 1'b1;
		end
	endfunction

	always @(posedge clk_sys) begin
		model_step(resetd, i_sync_raw);
	end

	////////////////////
	// Checking
	////////////////////

	task automatic check_sync(input vid_sync_t exp, input vid_sync_t act);
		if (act !== exp) begin
			$display("Mismatch at %0t: o_sync expected hs=%b vs=%b, got hs=%b vs=%b",
				$time, exp.hs, exp.vs, act.hs, act.vs);
			$display("Verification failed");
			$fatal(1, "Normalised sync pair differs from the model");
		end
	endtask

	task automatic check_cs(input logic exp, input logic act);
		if (act !== exp) begin
			$display("Mismatch at %0t: o_cs expected %b, got %b", $time, exp, act);
			$display("Verification failed");
			$fatal(1, "Composite sync differs from the model");
		end
	endtask

	// Outputs are settled half a cycle after the edge
	always @(negedge clk_sys) begin
		if (m_live) begin
			check_sync(m_sync, o_sync);
			check_cs(m_cs, o_cs);
			n_checked++;
			if (m_mode == CS_VSYNC) begin
				n_vsync++;
			end
		end
	end

	task automatic wait_checked(input int target);
		int waited;
		waited = 0;
		while (n_checked < target) begin
			if (waited >= WAIT_LIMIT) begin
				$display("Verification failed");
				$fatal(1, "Timed out waiting for compare cycle %0d", target);
			end else begin
				@(posedge clk_sys);
				waited++;
			end
		end
	endtask

	// Two frames, vs rises together with the first hs of the frame
	task automatic drive_frames(input int h_period, input int h_pulse, input int lines,
		input int vs_lines, input logic hs_low, input logic vs_low);
		for (int f = 0; f < 2; f++) begin
			for (int l = 0; l < lines; l++) begin
				for (int c = 0; c < h_period; c++) begin
					@(posedge clk_sys);
					i_sync_raw.hs <= (c < h_pulse) ^ hs_low;
					i_sync_raw.vs <= (l < vs_lines) ^ vs_low;
				end
			end
		end
	endtask

	initial begin
		int   h_period;
		int   h_pulse;
		int   lines;
		int   vs_lines;
		logic hs_low;
		logic vs_low;
		resetd = 1'b1;
		i_sync_raw = '0;
		repeat (RST_CYCLES) @(posedge clk_sys);
		resetd <= 1'b0;
		// Idle inputs, outputs must hold at zero
		wait_checked(n_checked + 8);
		for (int s = 0; s < FRAME_SETS; s++) begin
			h_period = pick(16, 32);
			h_pulse = pick(2, h_period / 2 - 2);
			lines = pick(8, 8);
			vs_lines = pick(2, 2);
			hs_low = (pick(0, 2) == 1);
			vs_low = (pick(0, 2) == 1);
			drive_frames(h_period, h_pulse, lines, vs_lines, hs_low, vs_low);
			wait_checked(n_checked + 6);
		end
		if (n_vsync > 0) begin
			$display("Verification passed");
			$finish;
		end else begin
			$display("Verification failed");
			$fatal(1, "No vertical sync cycles reached the checker");
		end
	end

endmodule

// ==== filelist.f ====
+incdir+design
design/vid_sync_pkg.sv
design/sync_polarity.sv
design/csync_gen.sv
design/vid_sync_top.sv
verif/vid_sync_props.sv
verif/tb_vid_sync.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_vid_sync
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
